// File: Makefile
TOP = arcade_input_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f filelist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
+incdir+hdl
hdl/arcade_input_pkg.sv
hdl/key_event_rx.sv
hdl/control_mapper.sv
hdl/input_port_mux.sv
hdl/arcade_input_top.sv
verification/arcade_input_tb.sv

// File: hdl/arcade_input_pkg.sv
`include "arcade_input_settings.svh"

package arcade_input_pkg;

	// one host keyboard event
	typedef struct packed {
		logic                   pressed; // 0 on release
		logic [`KEY_CODE_W-1:0] code;
	} key_event_t;

	// held controls, active high
	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic fire;
		logic left;
		logic right;
	} control_state_t;

	// keys the board cares about
	typedef enum logic [`KEY_CODE_W-1:0] {
		kc_up     = 8'h75,
		kc_down   = 8'h72,
		kc_left   = 8'h6B,
		kc_right  = 8'h74,
		kc_coin   = 8'h76, // esc
		kc_start1 = 8'h05, // f1
		kc_start2 = 8'h06, // f2
		kc_fire   = 8'h29  // space
	} key_code_e;

	typedef enum logic {
		port_ctrl = 1'b0,
		port_dip  = 1'b1
	} port_sel_e;

	// Joystick word layout as delivered by the host: bit0 right, bit1 left,
	// bit2 down, bit3 up, bit4 fire. Upper bits are extra buttons the game
	// does not use.
	localparam int joy_bit_right = 0;
	localparam int joy_bit_left  = 1;
	localparam int joy_bit_down  = 2;
	localparam int joy_bit_up    = 3;
	localparam int joy_bit_fire  = 4;

endpackage

// File: hdl/arcade_input_settings.svh
`ifndef ARCADE_INPUT_SETTINGS_SVH
`define ARCADE_INPUT_SETTINGS_SVH

// fixed by the game board

// ps/2 set 2 scancode
`define KEY_CODE_W 8

// host joystick word
`define JOY_W 8

// dip switch bank
`define DIP_W 8

// cpu input port byte
`define PORT_W 8

`endif

// File: hdl/arcade_input_top.sv
`timescale 1ns/1ps

`include "arcade_input_settings.svh"

module arcade_input_top (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         key_req,
	input  arcade_input_pkg::key_event_t key_evt,
	output logic                         key_ack,
	input  logic [`JOY_W-1:0]            joy0,
	input  logic [`JOY_W-1:0]            joy1,
	input  logic                         rotate,
	input  logic [`DIP_W-1:0]            dip,
	input  logic                         port_rd,
	input  arcade_input_pkg::port_sel_e  port_sel,
	output logic [`PORT_W-1:0]           port_data
);

	import arcade_input_pkg::*;

	logic           evt_strobe;
	key_event_t     evt;
	control_state_t ctrl;

	// host handshake in, one strobe per key event out
	key_event_rx u_key_event_rx (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.key_req    (key_req),
		.key_evt    (key_evt),
		.key_ack    (key_ack),
		.evt_strobe (evt_strobe),
		.evt        (evt)
	);

	control_mapper u_control_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.evt_strobe (evt_strobe),
		.evt        (evt),
		.joy0       (joy0),
		.joy1       (joy1),
		.rotate     (rotate),
		.ctrl       (ctrl)
	);

	// cpu side
	input_port_mux u_input_port_mux (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.dip       (dip),
		.port_rd   (port_rd),
		.port_sel  (port_sel),
		.port_data (port_data)
	);

endmodule

// File: hdl/control_mapper.sv
`timescale 1ns/1ps

`include "arcade_input_settings.svh"

module control_mapper (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             evt_strobe,
	input  arcade_input_pkg::key_event_t     evt,
	input  logic [`JOY_W-1:0]                joy0,
	input  logic [`JOY_W-1:0]                joy1,
	input  logic                             rotate,
	output arcade_input_pkg::control_state_t ctrl
);

	import arcade_input_pkg::*;

	// keyboard keys currently held down
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire;
	} held_keys_t;

	held_keys_t     held;
	held_keys_t     held_next;
	key_code_e      code;
	control_state_t ctrl_next;
	logic           joy_up;
	logic           joy_down;
	logic           joy_left;
	logic           joy_right;
	logic           joy_fire;

	assign code = key_code_e'(evt.code);

	always_comb begin
		held_next = held;
		if (evt_strobe) begin
			case (code)
				kc_up:     held_next.up     = evt.pressed;
				kc_down:   held_next.down   = evt.pressed;
				kc_left:   held_next.left   = evt.pressed;
				kc_right:  held_next.right  = evt.pressed;
				kc_coin:   held_next.coin   = evt.pressed;
				kc_start1: held_next.start1 = evt.pressed;
				kc_start2: held_next.start2 = evt.pressed;
				kc_fire:   held_next.fire   = evt.pressed;
				default:   held_next = held; // unmapped key
			endcase
		end
	end

	// either stick counts
	assign joy_up    = joy0[joy_bit_up]    | joy1[joy_bit_up];
	assign joy_down  = joy0[joy_bit_down]  | joy1[joy_bit_down];
	assign joy_left  = joy0[joy_bit_left]  | joy1[joy_bit_left];
	assign joy_right = joy0[joy_bit_right] | joy1[joy_bit_right];
	assign joy_fire  = joy0[joy_bit_fire]  | joy1[joy_bit_fire];

	// built from held_next so a key shows up one edge after its strobe
	always_comb begin
		ctrl_next.coin   = held_next.coin;
		ctrl_next.start1 = held_next.start1;
		ctrl_next.start2 = held_next.start2;
		ctrl_next.fire   = held_next.fire | joy_fire;
		if (rotate) begin
			ctrl_next.left  = held_next.left  | joy_left;
			ctrl_next.right = held_next.right | joy_right;
		end else begin
			ctrl_next.left  = held_next.up   | joy_up; // upright cabinet mapping
			ctrl_next.right = held_next.down | joy_down;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			held <= '0;
			ctrl <= '0;
		end else begin
			held <= held_next;
			ctrl <= ctrl_next;
		end
	end

	a_evt_known: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		evt_strobe |-> !$isunknown(evt)
	);

endmodule

// File: hdl/input_port_mux.sv
`timescale 1ns/1ps

`include "arcade_input_settings.svh"

module input_port_mux (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  arcade_input_pkg::control_state_t ctrl,
	input  logic [`DIP_W-1:0]                dip,
	input  logic                             port_rd,
	input  arcade_input_pkg::port_sel_e      port_sel,
	output logic [`PORT_W-1:0]               port_data
);

	import arcade_input_pkg::*;

	logic               coin_d;
	logic               coin_latch;
	logic               coin_rise;
	logic               ctrl_read;
	logic [`PORT_W-1:0] ctrl_byte;

	assign coin_rise = ctrl.coin & ~coin_d;
	assign ctrl_read = port_rd && (port_sel == port_ctrl);

	// coin stays latched until the game has seen it
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			coin_d     <= 1'b0;
			coin_latch <= 1'b0;
		end else begin
			coin_d <= ctrl.coin;
			if (coin_rise) begin
				coin_latch <= 1'b1;
			end else if (ctrl_read && !ctrl.coin) begin
				coin_latch <= 1'b0; // consumed by this read
			end
		end
	end

	// active low, 0 means pressed
	always_comb begin
		ctrl_byte    = '1;
		ctrl_byte[0] = ~coin_latch;
		ctrl_byte[1] = ~ctrl.start2;
		ctrl_byte[2] = ~ctrl.start1;
		ctrl_byte[4] = ~ctrl.fire;
		ctrl_byte[5] = ~ctrl.left;
		ctrl_byte[6] = ~ctrl.right;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			port_data <= '1; // idle, nothing pressed
		end else if (port_rd) begin
			case (port_sel)
				port_ctrl: port_data <= ctrl_byte;
				port_dip:  port_data <= dip;
				default:   port_data <= '1;
			endcase
		end
	end

	a_sel_known: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		port_rd |-> !$isunknown(port_sel)
	);

endmodule

// File: hdl/key_event_rx.sv
`timescale 1ns/1ps

module key_event_rx (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         key_req,
	input  arcade_input_pkg::key_event_t key_evt,
	output logic                         key_ack,
	output logic                         evt_strobe,
	output arcade_input_pkg::key_event_t evt
);

	typedef enum logic {
		st_idle,
		st_wait_release
	} rx_state_e;

	rx_state_e state;
	logic      accept;

	assign accept  = (state == st_idle) && key_req;
	assign key_ack = (state == st_wait_release); // ack is the state bit

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state      <= st_idle;
			evt_strobe <= 1'b0;
		end else begin
			evt_strobe <= accept; // one pulse per event
			case (state)
				st_idle: begin
					if (key_req) begin
						state <= st_wait_release;
					end
				end
				st_wait_release: begin
					if (!key_req) begin // host finished phase 3
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// event payload, valid with evt_strobe
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			evt <= key_evt;
		end
	end

	// the host must have a request up before we acknowledge it
	a_ack_follows_req: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		$rose(key_ack) |-> $past(key_req)
	);

endmodule

// File: verification/arcade_input_tb.sv
`timescale 1ns/1ps

`include "arcade_input_settings.svh"

module arcade_input_tb;

	import arcade_input_pkg::*;

	localparam int ack_timeout = 20;

	// keys the reference model believes are held
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire;
	} model_keys_t;

	logic               clk_sys;
	logic               rst_n;
	logic               key_req;
	key_event_t         key_evt;
	logic               key_ack;
	logic [`JOY_W-1:0]  joy0;
	logic [`JOY_W-1:0]  joy1;
	logic               rotate;
	logic [`DIP_W-1:0]  dip;
	logic               port_rd;
	port_sel_e          port_sel;
	logic [`PORT_W-1:0] port_data;

	model_keys_t keys;
	logic        latch;
	logic [31:0] rng_state;
	string       cur_test;
	int          test_checks;
	int          test_errors;
	int          checks;
	int          errors;
	int          tests_run;
	int          tests_failed;

	arcade_input_top uut (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.key_req   (key_req),
		.key_evt   (key_evt),
		.key_ack   (key_ack),
		.joy0      (joy0),
		.joy1      (joy1),
		.rotate    (rotate),
		.dip       (dip),
		.port_rd   (port_rd),
		.port_sel  (port_sel),
		.port_data (port_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [7:0] code_by_index(input logic [2:0] idx);
		case (idx)
			3'd0: return kc_up;
			3'd1: return kc_down;
			3'd2: return kc_left;
			3'd3: return kc_right;
			3'd4: return kc_coin;
			3'd5: return kc_start1;
			3'd6: return kc_start2;
			default: return kc_fire;
		endcase
	endfunction

	// port byte the game should see, joystick layout from the package rule
	function automatic logic [7:0] expected_ctrl_byte();
		logic want_fire;
		logic want_left;
		logic want_right;
		want_fire = keys.fire | joy0[4] | joy1[4];
		if (rotate) begin
			want_left  = keys.left | joy0[1] | joy1[1];
			want_right = keys.right | joy0[0] | joy1[0];
		end else begin
			want_left  = keys.up | joy0[3] | joy1[3];
			want_right = keys.down | joy0[2] | joy1[2];
		end
		return {1'b1, ~want_right, ~want_left, ~want_fire,
			1'b1, ~keys.start1, ~keys.start2, ~latch};
	endfunction

	task automatic apply_key(input logic pressed, input logic [7:0] code);
		case (code)
			kc_up:     keys.up = pressed;
			kc_down:   keys.down = pressed;
			kc_left:   keys.left = pressed;
			kc_right:  keys.right = pressed;
			kc_start1: keys.start1 = pressed;
			kc_start2: keys.start2 = pressed;
			kc_fire:   keys.fire = pressed;
			kc_coin: begin
				if (pressed && !keys.coin) begin
					latch = 1'b1; // rising coin
				end
				keys.coin = pressed;
			end
			default: ; // unmapped
		endcase
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("test %s finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
		tests_run++;
		checks += test_checks;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
	endtask

	task automatic check_value(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		test_checks++;
		assert (actual === expected) else begin
			$display("ERR %s %s expected %02h actual %02h", cur_test, what, expected, actual);
			test_errors++;
		end
	endtask

	// four-phase handshake, model follows once the host side is done
	task automatic send_key(input logic pressed, input logic [7:0] code);
		int waited;
		@(posedge clk_sys);
		key_evt <= {pressed, code};
		key_req <= 1'b1;
		waited = 0;
		do begin
			@(posedge clk_sys);
			waited++;
		end while (key_ack !== 1'b1 && waited < ack_timeout);
		test_checks++;
		assert (key_ack === 1'b1) else begin
			$display("%s: key_ack did not rise within %0d cycles of key_req",
				cur_test, ack_timeout);
			test_errors++;
		end
		key_req <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk_sys);
			waited++;
		end while (key_ack !== 1'b0 && waited < ack_timeout);
		test_checks++;
		assert (key_ack === 1'b0) else begin
			$display("%s: key_ack did not fall within %0d cycles after key_req dropped",
				cur_test, ack_timeout);
			test_errors++;
		end
		apply_key(pressed, code);
	endtask

	task automatic read_port(input port_sel_e sel, output logic [7:0] data);
		@(posedge clk_sys);
		port_rd  <= 1'b1;
		port_sel <= sel;
		@(posedge clk_sys);
		port_rd <= 1'b0;
		@(posedge clk_sys);
		data = port_data; // registered on the previous edge
	endtask

	task automatic check_ctrl(input string what);
		logic [7:0] expected;
		logic [7:0] got;
		expected = expected_ctrl_byte();
		read_port(port_ctrl, got);
		check_value(what, expected, got);
		if (!keys.coin) begin
			latch = 1'b0; // read consumes the coin
		end
	endtask

	task automatic set_inputs(input logic [7:0] j0, input logic [7:0] j1, input logic rot);
		@(posedge clk_sys);
		joy0   <= j0;
		joy1   <= j1;
		rotate <= rot;
		@(posedge clk_sys); // ctrl registers the change here
	endtask

	task automatic test_reset();
		logic [7:0] got;
		begin_test("reset");
		check_value("key_ack", 8'h00, {7'b0, key_ack});
		read_port(port_ctrl, got);
		check_value("port_ctrl", 8'hFF, got);
		read_port(port_dip, got);
		check_value("port_dip", dip, got);
		@(posedge clk_sys);
		dip <= 8'(next_rand() >> 24);
		read_port(port_dip, got);
		check_value("port_dip random", dip, got);
		end_test();
	endtask

	task automatic test_key_handshake();
		logic [7:0] unmapped[4];
		unmapped[0] = 8'h1C;
		unmapped[1] = 8'h00;
		unmapped[2] = 8'hF0;
		unmapped[3] = 8'h6C;
		begin_test("key_handshake");
		set_inputs(8'h00, 8'h00, 1'b1);
		for (int i = 0; i < 8; i++) begin
			send_key(1'b1, code_by_index(3'(i)));
			check_ctrl("press");
			send_key(1'b0, code_by_index(3'(i)));
			check_ctrl("release");
		end
		check_ctrl("idle after coin");
		for (int i = 0; i < 4; i++) begin
			send_key(1'b1, unmapped[i]);
			check_ctrl("unmapped press");
			send_key(1'b0, unmapped[i]);
			check_ctrl("unmapped release");
		end
		end_test();
	endtask

	task automatic test_rotate();
		begin_test("rotate");
		for (int r = 0; r < 2; r++) begin
			set_inputs(8'h00, 8'h00, r[0]);
			for (int i = 0; i < 4; i++) begin
				send_key(1'b1, code_by_index(3'(i))); // up, down, left, right
				check_ctrl("direction press");
				send_key(1'b0, code_by_index(3'(i)));
				check_ctrl("direction release");
			end
		end
		send_key(1'b1, kc_up);
		set_inputs(8'h00, 8'h00, 1'b0);
		check_ctrl("up held, rotate 0");
		set_inputs(8'h00, 8'h00, 1'b1);
		check_ctrl("up held, rotate 1");
		send_key(1'b0, kc_up);
		check_ctrl("up released");
		end_test();
	endtask

	task automatic test_joystick();
		begin_test("joystick");
		for (int r = 0; r < 2; r++) begin
			for (int b = 0; b < 8; b++) begin
				set_inputs(8'h01 << b, 8'h00, r[0]);
				check_ctrl("joy0 bit");
				set_inputs(8'h00, 8'h01 << b, r[0]);
				check_ctrl("joy1 bit");
			end
		end
		set_inputs(8'h10, 8'h00, 1'b1);
		send_key(1'b1, kc_fire);
		check_ctrl("fire key and stick");
		set_inputs(8'h00, 8'h00, 1'b1);
		check_ctrl("fire key only");
		send_key(1'b0, kc_fire);
		check_ctrl("fire released");
		set_inputs(8'h08, 8'h04, 1'b0);
		send_key(1'b1, kc_left);
		check_ctrl("sticks up/down, left key");
		set_inputs(8'h02, 8'h01, 1'b1);
		check_ctrl("sticks left/right, left key");
		send_key(1'b0, kc_left);
		set_inputs(8'h00, 8'h00, 1'b1);
		check_ctrl("all clear");
		end_test();
	endtask

	task automatic test_coin_latch();
		begin_test("coin_latch");
		send_key(1'b1, kc_coin);
		send_key(1'b0, kc_coin);
		check_ctrl("after coin pulse");
		check_ctrl("second read");
		send_key(1'b1, kc_coin);
		check_ctrl("coin held, first read");
		check_ctrl("coin held, second read");
		send_key(1'b0, kc_coin);
		check_ctrl("after release");
		check_ctrl("latch consumed");
		end_test();
	endtask

	task automatic test_random();
		logic [31:0] r;
		logic [31:0] j;
		logic [7:0]  code;
		begin_test("random");
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			j = next_rand();
			if (r[3]) begin
				code = r[15:8]; // mostly unmapped
			end else begin
				code = code_by_index(r[2:0]);
			end
			set_inputs(j[7:0] & j[23:16], j[15:8] & j[31:24], r[5]);
			send_key(r[4], code);
			check_ctrl($sformatf("event %0d code %02h", i, code));
		end
		end_test();
	endtask

	initial begin
		rst_n    <= 1'b0;
		key_req  <= 1'b0;
		key_evt  <= '0;
		joy0     <= '0;
		joy1     <= '0;
		rotate   <= 1'b1;
		dip      <= 8'hA5;
		port_rd  <= 1'b0;
		port_sel <= port_ctrl;
		keys      = '0;
		latch     = 1'b0;
		rng_state = 32'h358ff090;
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);
		test_reset();
		test_key_handshake();
		test_rotate();
		test_joystick();
		test_coin_latch();
		test_random();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
